/* hdl/system_pkg.sv */
package system_pkg;

   // address map
   localparam logic [15:0] ROM_BASE   = 16'hC000;
   localparam logic [15:0] RAM_TOP    = 16'h8FFF;
   localparam logic [7:0]  IO_PAGE    = 8'h92;
   localparam logic [15:0] VIDEO_BASE = 16'h9000;
   localparam logic [15:0] VIDEO_TOP  = 16'h907F;

   localparam int ROM_DEPTH = 32;     // indexed by addr[4:0]
   localparam int RAM_DEPTH = 65536;
   localparam string ROM_FILE = "hdl/boot_rom.hex";

   localparam logic [7:0] UNMAPPED_DATA = 8'hFF;
   localparam logic [7:0] VIDEO_DATA    = 8'h00;

   localparam int BUTTON_WIDTH = 5;

   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wr_data;
      logic        wr_en;
      logic        rd_req;
   } bus_req_t;

   typedef struct packed {
      logic [7:0] rd_data;
      logic       rd_valid;
      logic       ready;
   } bus_rsp_t;

   typedef enum logic [2:0] {REGION_NONE, REGION_RAM, REGION_ROM, REGION_IO, REGION_VIDEO} region_e;

   typedef enum logic [1:0] {BUS_IDLE, BUS_READ} bus_state_e;

   // zero is not a legal mode
   typedef enum logic [1:0] {
      VGA_MODE_640X480   = 2'd1,
      VGA_MODE_800X600   = 2'd2,
      VGA_MODE_1920X1080 = 2'd3
   } vga_mode_e;

   typedef enum logic [1:0] {
      IO_BUTTONS = 2'd0,
      IO_SCRATCH = 2'd1,
      IO_PRESSED = 2'd2,
      IO_MODE    = 2'd3
   } io_reg_e;

endpackage

/* hdl/bus_decoder.sv */
module bus_decoder import system_pkg::*; (
   input  logic        sys_clk,
   input  logic        reset_n,
   input  bus_req_t    bus_req,
   output bus_rsp_t    bus_rsp,
   output logic [15:0] ram_addr,
   output logic        ram_wr_en,
   output logic [4:0]  rom_addr,
   output io_reg_e     io_addr,
   output logic        io_wr_en,
   output logic [7:0]  wr_data,
   input  logic [7:0]  ram_q,
   input  logic [7:0]  rom_q,
   input  logic [7:0]  io_q
);

   region_e    region;
   region_e    region_r;   // region of the read in flight
   bus_state_e state;
   logic [7:0] io_q_r;
   logic [7:0] rd_mux;

   // video window wins over everything, then ram, io, rom
   always_comb begin
      if (bus_req.addr >= VIDEO_BASE && bus_req.addr <= VIDEO_TOP)
         region = REGION_VIDEO;
      else if (bus_req.addr <= RAM_TOP)
         region = REGION_RAM;
      else if (bus_req.addr[15:8] == IO_PAGE)
         region = REGION_IO;
      else if (bus_req.addr >= ROM_BASE)
         region = REGION_ROM;
      else
         region = REGION_NONE;
   end

   assign ram_addr  = bus_req.addr;
   assign rom_addr  = bus_req.addr[4:0];   // mirrored
   assign io_addr   = io_reg_e'(bus_req.addr[1:0]);
   assign wr_data   = bus_req.wr_data;
   assign ram_wr_en = bus_req.wr_en && (region == REGION_RAM);
   assign io_wr_en  = bus_req.wr_en && (region == REGION_IO);

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         state    <= BUS_IDLE;
         region_r <= REGION_NONE;
      end else if (bus_req.rd_req) begin
         state    <= BUS_READ;
         region_r <= region;
      end else begin
         state <= BUS_IDLE;
      end
   end

   // io is combinational, so hold it to line up with the memories
   always_ff @(posedge sys_clk) begin
      if (bus_req.rd_req)
         io_q_r <= io_q;
   end

   always_comb begin
      case (region_r)
         REGION_RAM:   rd_mux = ram_q;
         REGION_ROM:   rd_mux = rom_q;
         REGION_IO:    rd_mux = io_q_r;
         REGION_VIDEO: rd_mux = VIDEO_DATA;
         default:      rd_mux = UNMAPPED_DATA;
      endcase
   end

   always_comb begin
      bus_rsp.rd_data  = rd_mux;
      bus_rsp.rd_valid = (state == BUS_READ);
      bus_rsp.ready    = (state != BUS_READ);
   end

endmodule

/* hdl/ram_block.sv */
module ram_block import system_pkg::*; (
   input  logic        sys_clk,
   input  logic [15:0] addr,
   input  logic [7:0]  wr_data,
   input  logic        wr_en,
   output logic [7:0]  q
);

   logic [7:0] mem [RAM_DEPTH];

   // read returns old contents on a same-cycle write
   always_ff @(posedge sys_clk) begin
      if (wr_en)
         mem[addr] <= wr_data;
      q <= mem[addr];
   end

endmodule

/* hdl/rom_block.sv */
module rom_block import system_pkg::*; (
   input  logic       sys_clk,
   input  logic [4:0] addr,
   output logic [7:0] q
);

   logic [7:0] mem [ROM_DEPTH];

   initial begin
      $readmemh(ROM_FILE, mem);
   end

   always_ff @(posedge sys_clk) begin
      q <= mem[addr];   // one cycle read
   end

endmodule

/* hdl/io_ports.sv */
module io_ports import system_pkg::*; (
   input  logic                    sys_clk,
   input  logic                    reset_n,
   input  io_reg_e                 addr,
   input  logic [7:0]              wr_data,
   input  logic                    wr_en,
   input  logic [BUTTON_WIDTH-1:0] buttons,
   input  vga_mode_e               vga_mode,
   output logic [7:0]              q
);

   logic [BUTTON_WIDTH-1:0] btn_meta;
   logic [BUTTON_WIDTH-1:0] btn_sync;
   logic [BUTTON_WIDTH-1:0] btn_prev;
   logic [BUTTON_WIDTH-1:0] pressed;
   logic [BUTTON_WIDTH-1:0] press_set;
   logic [BUTTON_WIDTH-1:0] press_clr;
   logic [7:0]              scratch;

   assign press_set = btn_sync & ~btn_prev;   // rising edges
   assign press_clr = (wr_en && addr == IO_PRESSED) ? wr_data[BUTTON_WIDTH-1:0] : '0;

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         btn_meta <= '0;
         btn_sync <= '0;
         btn_prev <= '0;
         pressed  <= '0;
         scratch  <= 8'h00;
      end else begin
         btn_meta <= buttons;
         btn_sync <= btn_meta;
         btn_prev <= btn_sync;
         // set wins over a clear in the same cycle
         pressed  <= (pressed & ~press_clr) | press_set;
         if (wr_en && addr == IO_SCRATCH)
            scratch <= wr_data;
      end
   end

   always_comb begin
      case (addr)
         IO_BUTTONS: q = {{(8-BUTTON_WIDTH){1'b0}}, btn_sync};
         IO_SCRATCH: q = scratch;
         IO_PRESSED: q = {{(8-BUTTON_WIDTH){1'b0}}, pressed};
         IO_MODE:    q = {6'b0, vga_mode};
         default:    q = 8'h00;
      endcase
   end

endmodule

/* hdl/mode_selector.sv */
module mode_selector import system_pkg::*; (
   input  logic      sys_clk,
   input  logic      reset_n,
   input  logic      key_mode,
   output vga_mode_e vga_mode
);

   logic key_meta;
   logic key_sync;
   logic key_prev;
   logic key_release;

   assign key_release = key_prev & ~key_sync;   // high to low

   always_ff @(posedge sys_clk) begin
      if (!reset_n) begin
         key_meta <= 1'b0;
         key_sync <= 1'b0;
         key_prev <= 1'b0;
         vga_mode <= VGA_MODE_1920X1080;
      end else begin
         key_meta <= key_mode;
         key_sync <= key_meta;
         key_prev <= key_sync;
         if (vga_mode == vga_mode_e'(2'd0))
            vga_mode <= VGA_MODE_1920X1080;   // back to a legal mode
         else if (key_release) begin
            case (vga_mode)
               VGA_MODE_640X480:   vga_mode <= VGA_MODE_800X600;
               VGA_MODE_800X600:   vga_mode <= VGA_MODE_1920X1080;
               VGA_MODE_1920X1080: vga_mode <= VGA_MODE_640X480;
               default:            vga_mode <= VGA_MODE_1920X1080;
            endcase
         end
      end
   end

endmodule

/* hdl/system_bus.sv */
module system_bus import system_pkg::*; (
   input  logic                    sys_clk,
   input  logic                    reset_n,
   input  bus_req_t                bus_req,
   output bus_rsp_t                bus_rsp,
   input  logic [BUTTON_WIDTH-1:0] buttons,
   input  logic                    key_mode,
   output vga_mode_e               vga_mode
);

   logic [15:0] ram_addr;
   logic        ram_wr_en;
   logic [4:0]  rom_addr;
   io_reg_e     io_addr;
   logic        io_wr_en;
   logic [7:0]  wr_data;
   logic [7:0]  ram_q;
   logic [7:0]  rom_q;
   logic [7:0]  io_q;

   bus_decoder u_bus_decoder (
      .sys_clk   (sys_clk),
      .reset_n   (reset_n),
      .bus_req   (bus_req),
      .bus_rsp   (bus_rsp),
      .ram_addr  (ram_addr),
      .ram_wr_en (ram_wr_en),
      .rom_addr  (rom_addr),
      .io_addr   (io_addr),
      .io_wr_en  (io_wr_en),
      .wr_data   (wr_data),
      .ram_q     (ram_q),
      .rom_q     (rom_q),
      .io_q      (io_q)
   );

   ram_block u_ram_block (
      .sys_clk (sys_clk),
      .addr    (ram_addr),
      .wr_data (wr_data),
      .wr_en   (ram_wr_en),
      .q       (ram_q)
   );

   rom_block u_rom_block (
      .sys_clk (sys_clk),
      .addr    (rom_addr),
      .q       (rom_q)
   );

   io_ports u_io_ports (
      .sys_clk  (sys_clk),
      .reset_n  (reset_n),
      .addr     (io_addr),
      .wr_data  (wr_data),
      .wr_en    (io_wr_en),
      .buttons  (buttons),
      .vga_mode (vga_mode),
      .q        (io_q)
   );

   mode_selector u_mode_selector (
      .sys_clk  (sys_clk),
      .reset_n  (reset_n),
      .key_mode (key_mode),
      .vga_mode (vga_mode)
   );

endmodule

/* verif/system_bus_properties.sv */
module system_bus_properties import system_pkg::*; (
   input logic      sys_clk,
   input logic      reset_n,
   input bus_req_t  bus_req,
   input bus_rsp_t  bus_rsp,
   input vga_mode_e vga_mode
);
   timeunit 1ns;
   timeprecision 1ps;

   read_answers_next_cycle: assert property (@(posedge sys_clk) disable iff (!reset_n)
      bus_req.rd_req |=> bus_rsp.rd_valid)
      else $error("rd_valid did not follow rd_req by one cycle");

   // no response without a request the cycle before
   valid_needs_request: assert property (@(posedge sys_clk) disable iff (!reset_n)
      bus_rsp.rd_valid |-> $past(bus_req.rd_req))
      else $error("rd_valid high without a preceding rd_req");

   // ready drops only for the cycle after a read request
   ready_low_during_read: assert property (@(posedge sys_clk) disable iff (!reset_n)
      bus_rsp.ready == !$past(bus_req.rd_req))
      else $error("ready not low exactly in the cycle after rd_req");

   mode_never_zero: assert property (@(posedge sys_clk) disable iff (!reset_n)
      vga_mode != vga_mode_e'(2'd0))
      else $error("vga_mode is zero");

   idle_after_reset: assert property (@(posedge sys_clk)
      $rose(reset_n) |-> !bus_rsp.rd_valid)
      else $error("rd_valid high in the first cycle after reset");

endmodule

bind system_bus system_bus_properties u_system_bus_properties (
   .sys_clk  (sys_clk),
   .reset_n  (reset_n),
   .bus_req  (bus_req),
   .bus_rsp  (bus_rsp),
   .vga_mode (vga_mode)
);

/* verif/system_bus_tb.sv */
module system_bus_tb import system_pkg::*; ();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD  = 40;
   localparam int NUM_TXN     = 2000;
   localparam int WATCHDOG_NS = NUM_TXN * 4 * CLK_PERIOD + 10_000;

   logic                    sys_clk;
   logic                    reset_n;
   bus_req_t                bus_req;
   bus_rsp_t                bus_rsp;
   logic [BUTTON_WIDTH-1:0] buttons;
   logic                    key_mode;
   vga_mode_e               vga_mode;

   // reference model
   logic [7:0]              ram_model [RAM_DEPTH];
   logic [7:0]              rom_model [ROM_DEPTH];
   logic [7:0]              scratch_model;
   logic [BUTTON_WIDTH-1:0] press_model;
   logic [BUTTON_WIDTH-1:0] btn_model;
   vga_mode_e               mode_model;
   logic [15:0]             written [$];   // ram addresses holding known data
   int                      checks;
   int                      errors;

   system_bus u_system_bus (
      .sys_clk  (sys_clk),
      .reset_n  (reset_n),
      .bus_req  (bus_req),
      .bus_rsp  (bus_rsp),
      .buttons  (buttons),
      .key_mode (key_mode),
      .vga_mode (vga_mode)
   );

   initial begin
      sys_clk = 1'b0;
      forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
   end

   initial begin
      #(WATCHDOG_NS * 1ns);
      $display("ERROR: the run timed out before all tests finished");
      $display("checks %0d, errors %0d", checks, errors);
      $display("RESULT: FAIL");
      $finish;
   end

   function automatic logic [15:0] io_address(input io_reg_e r);
      return {IO_PAGE, 6'b0, r};
   endfunction

   function automatic vga_mode_e next_mode(input vga_mode_e m);
      case (m)
         VGA_MODE_640X480: return VGA_MODE_800X600;
         VGA_MODE_800X600: return VGA_MODE_1920X1080;
         default:          return VGA_MODE_640X480;
      endcase
   endfunction

   function automatic logic [7:0] model_read(input logic [15:0] addr);
      if (addr >= VIDEO_BASE && addr <= VIDEO_TOP)
         return VIDEO_DATA;
      else if (addr <= RAM_TOP)
         return ram_model[addr];
      else if (addr[15:8] == IO_PAGE) begin
         case (addr[1:0])
            2'd0:    return {3'b0, btn_model};
            2'd1:    return scratch_model;
            2'd2:    return {3'b0, press_model};
            default: return {6'b0, mode_model};
         endcase
      end else if (addr >= ROM_BASE)
         return rom_model[addr[4:0]];
      else
         return UNMAPPED_DATA;
   endfunction

   function automatic void model_write(input logic [15:0] addr, input logic [7:0] data);
      if (addr >= VIDEO_BASE && addr <= VIDEO_TOP)
         return;   // dropped
      else if (addr <= RAM_TOP)
         ram_model[addr] = data;
      else if (addr[15:8] == IO_PAGE) begin
         if (addr[1:0] == 2'd1)
            scratch_model = data;
         else if (addr[1:0] == 2'd2)
            press_model = press_model & ~data[BUTTON_WIDTH-1:0];
      end
   endfunction

   task automatic flag_error(input string msg);
      errors++;
      $display("[FAIL] t=%0t %s", $time, msg);
   endtask

   task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
      bus_req = '0;
      bus_req.addr = addr;
      bus_req.wr_data = data;
      bus_req.wr_en = 1'b1;
      @(posedge sys_clk);
      @(negedge sys_clk);
      bus_req = '0;
      model_write(addr, data);
   endtask

   task automatic bus_read(input logic [15:0] addr);
      logic [7:0] exp;
      exp = model_read(addr);
      bus_req = '0;
      bus_req.addr = addr;
      bus_req.rd_req = 1'b1;
      @(posedge sys_clk);
      @(negedge sys_clk);
      bus_req = '0;
      checks++;
      if (bus_rsp.rd_valid !== 1'b1 || bus_rsp.ready !== 1'b0)
         flag_error($sformatf("no read response one cycle after rd_req at 0x%04h", addr));
      if (bus_rsp.rd_data !== exp)
         flag_error($sformatf("read 0x%04h got 0x%02h expected 0x%02h",
                              addr, bus_rsp.rd_data, exp));
   endtask

   task automatic press_buttons(input logic [BUTTON_WIDTH-1:0] value);
      buttons = value;
      repeat (4) @(negedge sys_clk);   // clear of the synchronizer
      press_model = press_model | (value & ~btn_model);
      btn_model = value;
      bus_read(io_address(IO_BUTTONS));
      bus_read(io_address(IO_PRESSED));
   endtask

   task automatic release_key();
      key_mode = 1'b1;
      repeat (4) @(negedge sys_clk);
      checks++;
      if (vga_mode !== mode_model)
         flag_error("vga_mode changed while the key was held");
      key_mode = 1'b0;
      repeat (5) @(negedge sys_clk);
      mode_model = next_mode(mode_model);
      checks++;
      if (vga_mode !== mode_model)
         flag_error($sformatf("vga_mode %0d expected %0d", vga_mode, mode_model));
      bus_read(io_address(IO_MODE));
   endtask

   initial begin
      int unsigned kind;
      logic [15:0] addr;
      logic [7:0]  data;
      void'($urandom(25));
      reset_n  = 1'b0;
      bus_req  = '0;
      buttons  = '0;
      key_mode = 1'b0;
      checks   = 0;
      errors   = 0;
      scratch_model = 8'h00;
      press_model   = '0;
      btn_model     = '0;
      mode_model    = VGA_MODE_1920X1080;
      $readmemh(ROM_FILE, rom_model);
      repeat (10) @(negedge sys_clk);
      reset_n = 1'b1;
      @(negedge sys_clk);

      checks++;
      if (bus_rsp.ready !== 1'b1 || bus_rsp.rd_valid !== 1'b0)
         flag_error("bus not idle after reset");
      checks++;
      if (vga_mode !== VGA_MODE_1920X1080)
         flag_error($sformatf("vga_mode %0d after reset expected 3", vga_mode));
      bus_read(io_address(IO_MODE));

      for (int i = 0; i < NUM_TXN; i++) begin
         kind = $urandom_range(0, 5);
         data = 8'($urandom);
         case (kind)
            0: begin
               addr = 16'($urandom_range(0, RAM_TOP));
               bus_write(addr, data);
               written.push_back(addr);
            end
            1: begin
               if (written.size() > 0)
                  bus_read(written[$urandom_range(0, written.size() - 1)]);
            end
            2: begin   // read straight after write
               addr = 16'($urandom_range(0, RAM_TOP));
               bus_write(addr, data);
               written.push_back(addr);
               bus_read(addr);
            end
            3: addr = 16'($urandom_range(ROM_BASE, 16'hFFFF));
            4: begin
               if ($urandom_range(0, 1))
                  addr = 16'($urandom_range(VIDEO_BASE, VIDEO_TOP));
               else
                  addr = 16'($urandom_range(VIDEO_TOP + 1, ROM_BASE - 1));
            end
            default: addr = {IO_PAGE, 8'($urandom)};
         endcase
         if (kind >= 3) begin
            if ($urandom_range(0, 1))
               bus_write(addr, data);
            bus_read(addr);
         end
      end

      for (int i = 0; i < 20; i++) begin
         press_buttons(BUTTON_WIDTH'($urandom));
         bus_write(io_address(IO_PRESSED), 8'($urandom));
         bus_read(io_address(IO_PRESSED));
      end

      repeat (6) release_key();

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* system_bus.f */
hdl/system_pkg.sv
hdl/bus_decoder.sv
hdl/ram_block.sv
hdl/rom_block.sv
hdl/io_ports.sv
hdl/mode_selector.sv
hdl/system_bus.sv
verif/system_bus_properties.sv
verif/system_bus_tb.sv

/* hdl/boot_rom.hex */
// one hex byte per line, rom index 0 to 31
A9
00
8D
01
92
A2
FF
9A
AD
00
92
29
1F
F0
F9
8D
01
92
AD
02
92
8D
02
92
4C
00
C0
EA
EA
00
C0
00
